//--- common_pkg.sv
// Widths, bus map, CRTC register numbers and shared types of the video block
// Bus addresses are word addresses with one byte per word
package common_pkg;
    localparam int WB_ADDR_WIDTH = 17;    // Wishbone word address
    localparam int DATA_WIDTH    = 8;     // One byte per bus word
    localparam int MA_WIDTH      = 14;    // CRTC refresh address
    localparam int RA_WIDTH      = 5;     // CRTC raster address

    localparam logic [WB_ADDR_WIDTH-1:0] VRAM_BASE = 17'h0_8000;  // 2 KB display RAM
    localparam logic [WB_ADDR_WIDTH-1:0] VROM_BASE = 17'h1_8000;  // 4 KB character ROM

    // Register numbers follow the 6845, unsupported ones are absent
    localparam logic [4:0] R_H_TOTAL    = 5'd0;   // Characters per line minus one
    localparam logic [4:0] R_H_DISP     = 5'd1;   // Displayed characters per line
    localparam logic [4:0] R_H_SYNC_POS = 5'd2;
    localparam logic [4:0] R_SYNC_WIDTH = 5'd3;   // Low nibble horizontal, high nibble vertical
    localparam logic [4:0] R_V_TOTAL    = 5'd4;   // Rows per frame minus one
    localparam logic [4:0] R_V_DISP     = 5'd6;   // Displayed rows
    localparam logic [4:0] R_V_SYNC_POS = 5'd7;
    localparam logic [4:0] R_MAX_SCAN   = 5'd9;   // Scan lines per row minus one
    localparam logic [4:0] R_START_HI   = 5'd12;
    localparam logic [4:0] R_START_LO   = 5'd13;

    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;    // Word address
        logic [DATA_WIDTH-1:0]    data;    // Write data, unused by the reader
        logic                     we;      // Always a read here
    } wb_req_t;

    typedef struct packed {
        logic                hsync;
        logic                vsync;
        logic                de;           // Display enable
        logic [MA_WIDTH-1:0] ma;           // Refresh address
        logic [RA_WIDTH-1:0] ra;           // Scan line within the row
    } crtc_out_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] even_char;
        logic [DATA_WIDTH-1:0] even_rom;
        logic [DATA_WIDTH-1:0] odd_char;   // Zero in 40 column mode
        logic [DATA_WIDTH-1:0] odd_rom;
    } glyph_t;

    // Display offset to bus address
    function automatic logic [WB_ADDR_WIDTH-1:0] wb_vram_addr(input logic [10:0] offset);
        return VRAM_BASE + WB_ADDR_WIDTH'(offset);
    endfunction

    // Glyph index {bank, set, char, line} to bus address
    function automatic logic [WB_ADDR_WIDTH-1:0] wb_vrom_addr(input logic [11:0] index);
        return VROM_BASE + WB_ADDR_WIDTH'(index);
    endfunction
endpackage

//--- run_sim.sh
#!/bin/sh
# Builds and runs the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module video_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/Vvideo_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "No verdict found in sim.log"
    exit 1
fi
exit 0

//--- sources.f
common_pkg.sv
video_crtc.sv
video_fetch.sv
video_dotgen.sv
video.sv
video_checker.sv
video_tb.sv

//--- video.sv
// Video block top, clock enables come from outside
// CRTC registers are write only
`timescale 1ns/100ps

module video (
    input  logic                              wb_clock_i,
    input  logic                              rst_n_i,

    output common_pkg::wb_req_t               wb_req_o,       // Wishbone B4 controller
    output logic                              wb_cycle_o,
    output logic                              wb_strobe_o,
    input  logic                              wb_stall_i,
    input  logic                              wb_ack_i,
    input  logic [common_pkg::DATA_WIDTH-1:0] wb_data_i,

    input  logic                              crtc_cs_i,      // CPU port
    input  logic                              crtc_we_i,
    input  logic                              crtc_rs_i,
    input  logic                              wr_strobe_i,
    input  logic [common_pkg::DATA_WIDTH-1:0] crtc_data_i,

    input  logic                              cclk_en_i,      // Character clock enable
    input  logic                              clk8_en_i,
    input  logic                              clk16_en_i,

    input  logic                              col_80_mode_i,  // Low for 40 columns
    input  logic                              graphic_i,      // Character set select

    output logic                              h_sync_o,
    output logic                              v_sync_o,
    output logic                              video_o
);
    common_pkg::crtc_out_t timing;
    common_pkg::glyph_t    glyph;

    video_crtc video_crtc (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .cclk_en_i   (cclk_en_i),
        .wr_strobe_i (wr_strobe_i),
        .crtc_cs_i   (crtc_cs_i),
        .crtc_we_i   (crtc_we_i),
        .crtc_rs_i   (crtc_rs_i),
        .crtc_data_i (crtc_data_i),
        .timing_o    (timing)
    );

    video_fetch video_fetch (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .cclk_en_i     (cclk_en_i),
        .col_80_mode_i (col_80_mode_i),
        .graphic_i     (graphic_i),
        .timing_i      (timing),
        .wb_data_i     (wb_data_i),
        .wb_stall_i    (wb_stall_i),
        .wb_ack_i      (wb_ack_i),
        .wb_req_o      (wb_req_o),
        .wb_cycle_o    (wb_cycle_o),
        .wb_strobe_o   (wb_strobe_o),
        .glyph_o       (glyph)
    );

    video_dotgen video_dotgen (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .cclk_en_i     (cclk_en_i),
        .clk8_en_i     (clk8_en_i),
        .clk16_en_i    (clk16_en_i),
        .col_80_mode_i (col_80_mode_i),
        .timing_i      (timing),
        .glyph_i       (glyph),
        .video_o       (video_o)
    );

    assign h_sync_o = timing.hsync;   // Already registered in the CRTC
    assign v_sync_o = timing.vsync;
endmodule

//--- video_checker.sv
// Wishbone controller rules of the fetch engine checked through bind
// Assumes one request outstanding at a time as issued by the fetch engine
`timescale 1ns/100ps

module video_checker (
    input logic                wb_clock_i,
    input logic                rst_n_i,
    input common_pkg::wb_req_t wb_req_o,
    input logic                wb_cycle_o,
    input logic                wb_strobe_o,
    input logic                wb_stall_i,
    input logic                wb_ack_i
);
    logic outstanding;                                 // Accepted request not yet acked
    int   fail_count = 0;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding <= 1'b0;
        end else if (wb_strobe_o && !wb_stall_i) begin
            outstanding <= 1'b1;
        end else if (wb_ack_i) begin
            outstanding <= 1'b0;
        end
    end

    // Stalled request must be held unchanged
    held_under_stall: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_strobe_o && wb_stall_i |=> wb_strobe_o && $stable(wb_req_o))
        else begin
            $error("Request changed or dropped while stalled");
            fail_count++;
        end

    ack_has_request: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_ack_i |-> outstanding)
        else begin
            $error("Ack arrived with no outstanding request");
            fail_count++;
        end

    strobe_in_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_strobe_o |-> wb_cycle_o)
        else begin
            $error("Strobe high outside a bus cycle");
            fail_count++;
        end
endmodule

bind video_fetch video_checker wb_rules (
    .wb_clock_i  (wb_clock_i),
    .rst_n_i     (rst_n_i),
    .wb_req_o    (wb_req_o),
    .wb_cycle_o  (wb_cycle_o),
    .wb_strobe_o (wb_strobe_o),
    .wb_stall_i  (wb_stall_i),
    .wb_ack_i    (wb_ack_i)
);

//--- video_crtc.sv
// Write-only CRTC subset, no cursor, light pen, interlace or vertical adjust
// All registers clear on reset, which gives a one-character, one-line frame
`timescale 1ns/100ps

module video_crtc (
    input  logic                            wb_clock_i,
    input  logic                            rst_n_i,
    input  logic                            cclk_en_i,     // Character clock enable
    input  logic                            wr_strobe_i,   // CPU write strobe
    input  logic                            crtc_cs_i,     // Chip select from address decode
    input  logic                            crtc_we_i,     // High for a CPU write
    input  logic                            crtc_rs_i,     // Low selects the address register
    input  logic [common_pkg::DATA_WIDTH-1:0] crtc_data_i,
    output common_pkg::crtc_out_t           timing_o
);
    logic [4:0] addr_q;       // Selected register
    logic [7:0] h_total;      // R0
    logic [7:0] h_disp;       // R1
    logic [7:0] h_sync_pos;   // R2
    logic [7:0] sync_width;   // R3
    logic [7:0] v_total;      // R4
    logic [7:0] v_disp;       // R6
    logic [7:0] v_sync_pos;   // R7
    logic [7:0] max_scan;     // R9
    logic [7:0] start_hi;     // R12
    logic [7:0] start_lo;     // R13

    logic [7:0] h_count;
    logic [4:0] ra_count;
    logic [6:0] row_count;
    logic [3:0] v_left;       // Vertical sync lines still to go
    logic [4:0] ra_next;
    logic [6:0] row_next;
    logic [common_pkg::MA_WIDTH-1:0] ma_calc;

    wire cpu_wr    = wr_strobe_i && crtc_cs_i && crtc_we_i;
    wire line_end  = h_count >= h_total;                    // Also recovers if R0 shrinks
    wire last_scan = ra_count >= max_scan[4:0];
    wire last_row  = row_count >= v_total[6:0];
    wire h_sync    = (h_count >= h_sync_pos)
                     && ((h_count - h_sync_pos) < {4'b0, sync_width[3:0]});
    wire de        = (h_count < h_disp) && (row_count < v_disp[6:0]);

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q     <= '0;
            h_total    <= '0;
            h_disp     <= '0;
            h_sync_pos <= '0;
            sync_width <= '0;
            v_total    <= '0;
            v_disp     <= '0;
            v_sync_pos <= '0;
            max_scan   <= '0;
            start_hi   <= '0;
            start_lo   <= '0;
        end else if (cpu_wr) begin
            if (!crtc_rs_i) begin
                addr_q <= crtc_data_i[4:0];
            end else begin
                case (addr_q)
                    common_pkg::R_H_TOTAL:    h_total    <= crtc_data_i;
                    common_pkg::R_H_DISP:     h_disp     <= crtc_data_i;
                    common_pkg::R_H_SYNC_POS: h_sync_pos <= crtc_data_i;
                    common_pkg::R_SYNC_WIDTH: sync_width <= crtc_data_i;
                    common_pkg::R_V_TOTAL:    v_total    <= crtc_data_i;
                    common_pkg::R_V_DISP:     v_disp     <= crtc_data_i;
                    common_pkg::R_V_SYNC_POS: v_sync_pos <= crtc_data_i;
                    common_pkg::R_MAX_SCAN:   max_scan   <= crtc_data_i;
                    common_pkg::R_START_HI:   start_hi   <= crtc_data_i;
                    common_pkg::R_START_LO:   start_lo   <= crtc_data_i;
                    default: ;                                   // Unsupported registers ignore writes
                endcase
            end
        end
    end

    always_comb begin
        ra_next  = last_scan ? 5'd0 : ra_count + 5'd1;
        row_next = row_count;
        if (last_scan) begin
            row_next = last_row ? 7'd0 : row_count + 7'd1;
        end
        ma_calc = {start_hi[5:0], start_lo}
                  + 14'(row_count) * 14'(h_disp)
                  + 14'(h_count);
    end

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_count   <= '0;
            ra_count  <= '0;
            row_count <= '0;
            v_left    <= '0;
            timing_o  <= '0;
        end else if (cclk_en_i) begin
            timing_o.hsync <= h_sync;                            // Outputs trail the count by one clock
            timing_o.vsync <= v_left != 4'd0;
            timing_o.de    <= de;
            timing_o.ma    <= ma_calc;
            timing_o.ra    <= ra_count;
            if (line_end) begin
                h_count   <= '0;
                ra_count  <= ra_next;
                row_count <= row_next;
                if (ra_next == 5'd0 && row_next == v_sync_pos[6:0]) begin
                    v_left <= sync_width[7:4];                   // Sync starts on line 0 of row R7
                end else if (v_left != 4'd0) begin
                    v_left <= v_left - 4'd1;
                end
            end else begin
                h_count <= h_count + 8'd1;
            end
        end
    end
endmodule

//--- video_dotgen.sv
// Shifts glyph bytes out MSB first, one character period behind the fetch
// 40 column mode shows only the even byte
`timescale 1ns/100ps

module video_dotgen (
    input  logic                  wb_clock_i,
    input  logic                  rst_n_i,
    input  logic                  cclk_en_i,
    input  logic                  clk8_en_i,      // 40 column pixel rate
    input  logic                  clk16_en_i,     // 80 column pixel rate
    input  logic                  col_80_mode_i,
    input  common_pkg::crtc_out_t timing_i,
    input  common_pkg::glyph_t    glyph_i,
    output logic                  video_o
);
    logic        load_q;
    logic        de_prev;     // Enable of the cell now being fetched
    logic        de_q;        // Enable of the cell now on screen
    logic [15:0] shift_q;

    wire       pixel_en = col_80_mode_i ? clk16_en_i : clk8_en_i;
    wire       no_row   = timing_i.ra[3] || timing_i.ra[4];       // ROM holds 8 lines only
    wire [7:0] even_pix = glyph_i.even_rom ^ {8{glyph_i.even_char[7]}};
    wire [7:0] odd_pix  = glyph_i.odd_rom ^ {8{glyph_i.odd_char[7]}};

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_q  <= 1'b0;
            de_prev <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            load_q <= cclk_en_i;
            if (load_q) begin
                de_q    <= de_prev;                    // Follows the glyph by one period
                de_prev <= timing_i.de && !no_row;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (load_q) begin
            shift_q <= {even_pix, odd_pix};
        end else if (pixel_en) begin
            shift_q <= {shift_q[14:0], 1'b0};
        end
    end

    assign video_o = de_q && shift_q[15];
endmodule

//--- video_fetch.sv
// Reads two or four bytes per character period over pipelined Wishbone B4
// One request outstanding at a time; an overrunning batch delays the next one
`timescale 1ns/100ps

module video_fetch (
    input  logic                              wb_clock_i,
    input  logic                              rst_n_i,
    input  logic                              cclk_en_i,
    input  logic                              col_80_mode_i,
    input  logic                              graphic_i,      // Character set select
    input  common_pkg::crtc_out_t             timing_i,
    input  logic [common_pkg::DATA_WIDTH-1:0] wb_data_i,
    input  logic                              wb_stall_i,
    input  logic                              wb_ack_i,
    output common_pkg::wb_req_t               wb_req_o,
    output logic                              wb_cycle_o,
    output logic                              wb_strobe_o,
    output common_pkg::glyph_t                glyph_o
);
    typedef enum logic {IDLE, AWAIT_ACK} state_t;
    typedef enum logic [1:0] {EVEN_RAM, EVEN_ROM, ODD_RAM, ODD_ROM} stage_t;

    state_t state;
    stage_t stage;
    logic   start_q;                                   // Cycle after the character enable
    logic   pending;                                   // Start seen while busy
    logic   col80_q;                                   // Mode of the running batch
    logic [common_pkg::MA_WIDTH-1:0]   ma_q;
    logic [2:0]                        ra_q;
    logic [common_pkg::DATA_WIDTH-1:0] even_char_q;
    logic [common_pkg::DATA_WIDTH-1:0] even_rom_q;
    logic [common_pkg::DATA_WIDTH-1:0] odd_char_q;

    function automatic logic [common_pkg::WB_ADDR_WIDTH-1:0] ram_addr(
        input logic [common_pkg::MA_WIDTH-1:0] ma,
        input logic                            col80,
        input logic                            odd
    );
        return common_pkg::wb_vram_addr(col80 ? {ma[9:0], odd} : ma[10:0]);
    endfunction

    function automatic logic [common_pkg::WB_ADDR_WIDTH-1:0] rom_addr(
        input logic [common_pkg::MA_WIDTH-1:0]   ma,
        input logic                              gfx,
        input logic [common_pkg::DATA_WIDTH-1:0] ch,
        input logic [2:0]                        ra
    );
        return common_pkg::wb_vrom_addr({ma[13], gfx, ch[6:0], ra});  // Bit 7 is reverse, not glyph
    endfunction

    wire accept = wb_strobe_o && !wb_stall_i;
    wire last   = col80_q ? (stage == ODD_ROM) : (stage == EVEN_ROM);

    always_ff @(posedge wb_clock_i) begin
        if (state == AWAIT_ACK && wb_ack_i) begin
            case (stage)
                EVEN_RAM: even_char_q <= wb_data_i;
                EVEN_ROM: even_rom_q  <= wb_data_i;
                ODD_RAM:  odd_char_q  <= wb_data_i;
                default: ;                             // Last byte goes straight to glyph_o
            endcase
        end
    end

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            stage       <= EVEN_RAM;
            start_q     <= 1'b0;
            pending     <= 1'b0;
            col80_q     <= 1'b0;
            ma_q        <= '0;
            ra_q        <= '0;
            wb_req_o    <= '0;                         // Reads only, data and we stay zero
            wb_cycle_o  <= 1'b0;
            wb_strobe_o <= 1'b0;
            glyph_o     <= '0;
        end else begin
            start_q <= cclk_en_i;
            case (state)
                IDLE: begin
                    if (start_q || pending) begin
                        pending       <= 1'b0;
                        ma_q          <= timing_i.ma;
                        ra_q          <= timing_i.ra[2:0];
                        col80_q       <= col_80_mode_i;
                        stage         <= EVEN_RAM;
                        wb_req_o.addr <= ram_addr(timing_i.ma, col_80_mode_i, 1'b0);
                        wb_cycle_o    <= 1'b1;
                        wb_strobe_o   <= 1'b1;
                        state         <= AWAIT_ACK;
                    end
                end
                AWAIT_ACK: begin
                    if (start_q) begin
                        pending <= 1'b1;               // Batch overran its period
                    end
                    if (accept) begin
                        wb_strobe_o <= 1'b0;
                    end
                    if (wb_ack_i) begin
                        if (last) begin
                            wb_cycle_o        <= 1'b0;
                            state             <= IDLE;
                            glyph_o.even_char <= even_char_q;
                            if (col80_q) begin
                                glyph_o.even_rom <= even_rom_q;
                                glyph_o.odd_char <= odd_char_q;
                                glyph_o.odd_rom  <= wb_data_i;
                            end else begin
                                glyph_o.even_rom <= wb_data_i;
                                glyph_o.odd_char <= '0;
                                glyph_o.odd_rom  <= '0;
                            end
                        end else begin
                            stage       <= stage_t'(stage + 2'd1);
                            wb_strobe_o <= 1'b1;
                            if (stage == EVEN_ROM) begin
                                wb_req_o.addr <= ram_addr(ma_q, col80_q, 1'b1);
                            end else begin
                                wb_req_o.addr <= rom_addr(ma_q, graphic_i, wb_data_i, ra_q);
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end
endmodule

//--- video_tb.sv
// Directed testbench of the video block with a random-latency Wishbone memory model
// Address tests use one scan line per row so the ROM line bits are always zero
`timescale 1ns/100ps

module video_tb;
    localparam int FRAME_CLKS = 8 * 10 * 3 * 16;          // Video frame at 16 clocks per character
    localparam int TIMEOUT    = 8 * FRAME_CLKS + 4 * 64 * 16 + 2000;

    logic wb_clock_i;
    logic rst_n_i;
    common_pkg::wb_req_t wb_req_o;
    logic wb_cycle_o, wb_strobe_o, wb_stall_i, wb_ack_i;
    logic [common_pkg::DATA_WIDTH-1:0] wb_data_i, crtc_data_i;
    logic crtc_cs_i, crtc_we_i, crtc_rs_i, wr_strobe_i;
    logic cclk_en_i, clk8_en_i, clk16_en_i, col_80_mode_i, graphic_i;
    logic h_sync_o, v_sync_o, video_o;

    logic [7:0] mem [0:2**common_pkg::WB_ADDR_WIDTH-1];
    logic [common_pkg::WB_ADDR_WIDTH-1:0] req_log [$];    // Accepted request addresses
    int max_stall = 0;
    int max_delay = 1;
    int stall_left = 0;
    int ack_wait = 0;
    bit stall_armed = 0;
    logic [7:0] rd_data;
    logic [3:0] en_count;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int seed_val;

    video dut (.*);

    initial begin
        wb_clock_i = 1'b0;
        forever #10 wb_clock_i = ~wb_clock_i;
    end

    always @(posedge wb_clock_i) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Enables from a free-running counter with a character enable every 16 clocks
    always @(posedge wb_clock_i) begin
        #2;
        if (rst_n_i) begin
            en_count   = en_count + 4'd1;
            clk16_en_i = 1'b1;
            clk8_en_i  = en_count[0];
            cclk_en_i  = en_count == 4'hf;
        end
    end

    // Memory model accepts at a sampled strobe and acks after a random delay
    always begin
        @(negedge wb_clock_i);
        if (wb_strobe_o && !wb_stall_i) begin
            req_log.push_back(wb_req_o.addr);
            check_bit("read request we", 1'b0, wb_req_o.we);
            rd_data     = mem[wb_req_o.addr];
            ack_wait    = 1 + $urandom % max_delay;
            stall_armed = 1'b0;
        end
        @(posedge wb_clock_i);
        #2;
        wb_ack_i = 1'b0;
        if (ack_wait > 0) begin
            ack_wait--;
            if (ack_wait == 0) begin
                wb_ack_i  = 1'b1;
                wb_data_i = rd_data;
            end
        end
        if (wb_strobe_o && !stall_armed) begin
            stall_left  = $urandom % (max_stall + 1);    // Pick the stall of a new request
            stall_armed = 1'b1;
        end
        wb_stall_i = stall_left > 0;
        if (stall_left > 0) stall_left--;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [common_pkg::WB_ADDR_WIDTH-1:0] exp,
                              input logic [common_pkg::WB_ADDR_WIDTH-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s expected %05h actual %05h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Fail %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic int ones(input logic [7:0] b);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) n += b[i];
        return n;
    endfunction

    // Glyph byte address from bank, set, character and line
    function automatic logic [common_pkg::WB_ADDR_WIDTH-1:0] rom_expect(
        input logic bank, input logic gfx, input logic [7:0] ch, input int line);
        return common_pkg::VROM_BASE + bank * 2048 + gfx * 1024 + ch[6:0] * 8 + line;
    endfunction

    task automatic wait_cclk(input int n);
        repeat (n) begin
            do @(negedge wb_clock_i); while (!cclk_en_i);
        end
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [7:0] val);
        @(posedge wb_clock_i);
        #2;
        {crtc_cs_i, crtc_we_i, wr_strobe_i, crtc_rs_i} = 4'b1110;  // Address register
        crtc_data_i = {3'b0, idx};
        @(posedge wb_clock_i);
        #2;
        crtc_rs_i   = 1'b1;
        crtc_data_i = val;
        @(posedge wb_clock_i);
        #2;
        {crtc_cs_i, crtc_we_i, wr_strobe_i, crtc_rs_i} = 4'b0000;
    endtask

    task automatic program_frame(input logic [7:0] r9, input logic [13:0] start);
        write_reg(common_pkg::R_H_TOTAL, 8'd7);       // 8 characters per line
        write_reg(common_pkg::R_H_DISP, 8'd4);
        write_reg(common_pkg::R_H_SYNC_POS, 8'd5);
        write_reg(common_pkg::R_SYNC_WIDTH, 8'h21);   // Horizontal 1 char and vertical 2 lines
        write_reg(common_pkg::R_V_TOTAL, 8'd2);       // 3 rows
        write_reg(common_pkg::R_V_DISP, 8'd2);
        write_reg(common_pkg::R_V_SYNC_POS, 8'd2);
        write_reg(common_pkg::R_MAX_SCAN, r9);
        write_reg(common_pkg::R_START_HI, {2'b0, start[13:8]});
        write_reg(common_pkg::R_START_LO, start[7:0]);
    endtask

    task automatic test_reset();
        repeat (4) begin
            @(negedge wb_clock_i);
            check_bit("reset cycle", 1'b0, wb_cycle_o);
            check_bit("reset strobe", 1'b0, wb_strobe_o);
            check_bit("reset hsync", 1'b0, h_sync_o);
            check_bit("reset vsync", 1'b0, v_sync_o);
            check_bit("reset video", 1'b0, video_o);
        end
    endtask

    task automatic measure_sync(input bit vert, output int period, output int high);
        bit prev, cur;
        period = 0;
        high   = 0;
        wait_cclk(1);
        prev = vert ? v_sync_o : h_sync_o;
        forever begin
            wait_cclk(1);
            cur = vert ? v_sync_o : h_sync_o;
            if (!prev && cur) break;                      // Rising edge found
            prev = cur;
        end
        do begin
            high  += cur;
            period++;
            prev = cur;
            wait_cclk(1);
            cur = vert ? v_sync_o : h_sync_o;
        end while (prev || !cur);
    endtask

    task automatic test_sync();
        int period, high;
        measure_sync(1'b0, period, high);
        check_count("hsync period", 8, period);
        check_count("hsync high", 1, high);
        measure_sync(1'b1, period, high);
        check_count("vsync period", 3 * 10 * 8, period);
        check_count("vsync high", 2 * 8, high);
    endtask

    // Fetch with start 0x2010 and R9 = 0, so ma[13] = 1 and the line is always 0
    task automatic test_fetch(input string name, input bit col80, input bit gfx,
                              input int stall, input int delay, input int min_batches);
        logic [common_pkg::WB_ADDR_WIDTH-1:0] log_q [$];
        logic [common_pkg::WB_ADDR_WIDTH-1:0] a0;
        int i, n, step, off, lo, hi;
        @(posedge wb_clock_i);
        #2;
        col_80_mode_i = col80;
        graphic_i     = gfx;
        max_stall     = stall;
        max_delay     = delay;
        wait_cclk(3);
        req_log.delete();
        wait_cclk(48);
        log_q = req_log;
        step  = col80 ? 4 : 2;
        lo    = col80 ? 'h20 : 'h10;                      // Offset range of ma 0x2010..0x201f
        hi    = col80 ? 'h3e : 'h1f;
        i     = 0;
        n     = 0;
        // Overrunning batches can leave the log starting mid-batch
        while (i < log_q.size()
               && (log_q[i] >= common_pkg::VROM_BASE || (col80 && log_q[i][0]))) i++;
        while (i + step <= log_q.size()) begin
            a0  = log_q[i];
            off = a0 - common_pkg::VRAM_BASE;
            check_bit({name, " ram offset"}, 1'b1,
                      off >= lo && off <= hi && (!col80 || off % 2 == 0));
            check_addr({name, " even rom"}, rom_expect(1'b1, gfx, mem[a0], 0), log_q[i+1]);
            if (col80) begin
                check_addr({name, " odd ram"}, a0 + 1, log_q[i+2]);
                check_addr({name, " odd rom"}, rom_expect(1'b1, gfx, mem[a0+1], 0),
                           log_q[i+3]);
            end
            i += step;
            n++;
        end
        if (n < min_batches) begin
            errors++;
            $display("%s saw only %0d complete batches", name, n);
        end
    endtask

    // Counts pixels over one frame window since the picture repeats every frame
    task automatic test_video();
        int expected, seen;
        logic [13:0] ma;
        logic [7:0]  ch, rom;
        expected = 0;
        seen     = 0;
        for (int row = 0; row < 2; row++) begin
            for (int line = 0; line < 8; line++) begin
                for (int h = 0; h < 4; h++) begin
                    ma = 14'h0100 + row * 4 + h;
                    for (int k = 0; k < 2; k++) begin
                        ch  = mem[common_pkg::VRAM_BASE + ma[9:0] * 2 + k];
                        rom = mem[rom_expect(ma[13], graphic_i, ch, line)];
                        expected += ch[7] ? 8 - ones(rom) : ones(rom);
                    end
                end
            end
        end
        repeat (2) begin
            @(negedge wb_clock_i);
            while (v_sync_o) @(negedge wb_clock_i);
            while (!v_sync_o) @(negedge wb_clock_i);
        end
        repeat (FRAME_CLKS) begin
            @(negedge wb_clock_i);
            if (clk16_en_i && video_o) seen++;
        end
        check_count("video pixel count", expected, seen);
    endtask

    initial begin
        seed_val = $urandom(32'h471e_5a79);
        {wb_stall_i, wb_ack_i, wb_data_i, crtc_data_i} = '0;
        {crtc_cs_i, crtc_we_i, crtc_rs_i, wr_strobe_i} = '0;
        {cclk_en_i, clk8_en_i, clk16_en_i} = '0;
        col_80_mode_i = 1'b1;
        graphic_i     = 1'b1;
        en_count      = '0;
        rst_n_i       = 1'b0;
        for (int a = 0; a < 2**common_pkg::WB_ADDR_WIDTH; a++) mem[a] = 8'($urandom);
        fork
            test_reset();
        join_none
        repeat (8) @(posedge wb_clock_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge wb_clock_i);
        check_bit("post reset cycle", 1'b0, wb_cycle_o);
        check_bit("post reset video", 1'b0, video_o);

        program_frame(8'd9, 14'h0100);                    // 10 lines with lines 8 and 9 blank
        test_sync();
        max_delay = 1;                                    // No stalls and single-cycle acks
        test_video();

        program_frame(8'd0, 14'h2010);
        test_fetch("fetch 80 column", 1'b1, 1'b1, 2, 3, 20);
        test_fetch("fetch 40 column", 1'b0, 1'b0, 2, 3, 30);
        test_fetch("back-pressure", 1'b1, 1'b1, 6, 3, 10);

        errors += dut.video_fetch.wb_rules.fail_count;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule
